// File: source/packet_pkg.sv
/*
 * Shared packet stream definitions: the byte and metadata types, the
 * metadata width, default byte widths of the three stages and a helper
 * that sizes the empty-byte count for a given bus width.
 */

`default_nettype none

package packet_pkg;

    // One data byte on the stream, byte 0 is the leftmost on the bus
    typedef logic [7:0] byte_t;

    // Sideband metadata carried alongside every beat
    localparam int META_WID = 8;

    typedef logic [META_WID-1:0] meta_t;

    // Default byte widths of the input, buffered and output streams
    localparam int IN_BYTES  = 2;
    localparam int MID_BYTES = 8;
    localparam int OUT_BYTES = 4;

    // Width of the empty-byte count for a bus of the given byte width.
    // A one-byte bus still gets a single bit so that no vector is empty
    function automatic int mty_width(input int bytes);
        int wid;
        if (bytes > 1) begin
            wid = $clog2(bytes);
        end else begin
            wid = 1;
        end
        return wid;
    endfunction

endpackage : packet_pkg

`default_nettype wire

// File: source/packet_intf.sv
/*
 * Valid/ready packet stream interface with data, end-of-packet flag,
 * empty-byte count, error flag and metadata, plus tx and rx modports.
 */

`default_nettype none

interface packet_intf
    import packet_pkg::*;
#(
    parameter int DATA_BYTES = MID_BYTES
) ();

    localparam int MTY_WID = mty_width(DATA_BYTES);

    // Handshake, a beat moves when both are high on a clock edge
    logic                       vld;
    logic                       rdy;

    // Payload in network byte order, byte 0 goes first
    byte_t [0:DATA_BYTES-1]     data;
    logic                       eop;
    // Number of unused bytes at the right end, only meaningful with eop
    logic [MTY_WID-1:0]         mty;
    logic                       err;
    meta_t                      meta;

    modport tx (
        output vld, data, eop, mty, err, meta,
        input  rdy
    );

    modport rx (
        input  vld, data, eop, mty, err, meta,
        output rdy
    );

endinterface : packet_intf

`default_nettype wire

// File: source/packet_width_converter.sv
/*
 * Packet stream width converter. Packs narrow beats into wide words or
 * unpacks wide words into narrow beats, depending on the two bus widths.
 * Tracks start of packet and latches error and metadata sideband.
 */

`default_nettype none

module packet_width_converter
    import packet_pkg::*;
#(
    // Set to take metadata from the first beat of a packet only
    parameter bit LATCH_META_ON_SOP = 1'b1
) (
    input  logic    from_tx,
    input  logic    srst,
    packet_intf.rx  in_pkt,
    packet_intf.tx  out_pkt
);

    localparam int IN_W      = in_pkt.DATA_BYTES;
    localparam int OUT_W     = out_pkt.DATA_BYTES;
    localparam bit UPSIZE    = OUT_W > IN_W;
    localparam int RATIO     = UPSIZE ? OUT_W / IN_W : IN_W / OUT_W;
    localparam int MTY_IN_W  = mty_width(IN_W);
    localparam int MTY_OUT_W = mty_width(OUT_W);

    logic   in_acc;
    logic   out_acc;
    logic   sop;
    logic   err_q;
    meta_t  meta_q;

    assign in_acc  = in_pkt.vld && in_pkt.rdy;
    assign out_acc = out_pkt.vld && out_pkt.rdy;

    if (UPSIZE) begin : g_upsize

        // Number of narrow beats held in the wide word being built
        logic [$clog2(RATIO+1)-1:0]   pack_state;
        byte_t [0:RATIO-1][0:IN_W-1]  data_q;
        logic                         eop_q;
        logic [MTY_IN_W-1:0]          mty_q;

        // The word goes out once full, or early when the packet has ended
        assign out_pkt.vld = (pack_state == RATIO) || ((pack_state != '0) && eop_q);
        assign in_pkt.rdy  = out_pkt.rdy || !out_pkt.vld;

        always_ff @(posedge from_tx) begin
            if (srst) begin
                pack_state <= '0;
            end else if (out_acc) begin
                // A beat taken together with the old word starts the next one
                pack_state <= in_acc ? 1 : 0;
            end else if (in_acc) begin
                pack_state <= pack_state + 1'b1;
            end
        end

        // Fill slices from the left, so byte order is kept big-endian
        always_ff @(posedge from_tx) begin
            if (in_acc) begin
                if (out_acc) begin
                    data_q[0] <= in_pkt.data;
                end else begin
                    data_q[pack_state] <= in_pkt.data;
                end
                eop_q <= in_pkt.eop;
                mty_q <= in_pkt.mty;
            end
        end

        assign out_pkt.data = data_q;
        assign out_pkt.eop  = eop_q;

        // Empty bytes are the unfilled slices plus the gap in the last beat
        assign out_pkt.mty = eop_q ?
            MTY_OUT_W'(OUT_W - int'(pack_state) * IN_W + int'(mty_q)) : '0;

    end else begin : g_downsize

        // One bit per narrow slice still to be sent, slice 0 is next out
        logic [0:RATIO-1]              slice_vld;
        byte_t [0:RATIO-1][0:OUT_W-1]  data_q;
        logic                          eop_q;
        logic [MTY_IN_W-1:0]           mty_q;

        assign out_pkt.vld = slice_vld[0];

        // Accept a new wide word when idle or while the last slice leaves
        assign in_pkt.rdy = !slice_vld[0] || (!slice_vld[1] && out_pkt.rdy);

        always_ff @(posedge from_tx) begin
            if (srst) begin
                slice_vld <= '0;
            end else if (in_acc) begin
                // Only slices that hold at least one valid byte are sent
                for (int i = 0; i < RATIO; i++) begin
                    slice_vld[i] <= !in_pkt.eop || (int'(in_pkt.mty) < IN_W - i * OUT_W);
                end
            end else if (out_acc) begin
                slice_vld <= slice_vld << 1;
            end
        end

        always_ff @(posedge from_tx) begin
            if (in_acc) begin
                data_q <= in_pkt.data;
                eop_q  <= in_pkt.eop;
                mty_q  <= in_pkt.mty;
            end else if (out_acc) begin
                data_q <= data_q << (OUT_W * 8);
            end
        end

        assign out_pkt.data = data_q[0];
        assign out_pkt.eop  = eop_q && !slice_vld[1];
        assign out_pkt.mty  = MTY_OUT_W'(int'(mty_q) % OUT_W);

    end

    // Next accepted beat starts a packet after reset and after every eop
    always_ff @(posedge from_tx) begin
        if (srst) begin
            sop <= 1'b1;
        end else if (in_acc) begin
            sop <= in_pkt.eop;
        end
    end

    // Error follows every beat so the eop word carries the eop beat's flag
    always_ff @(posedge from_tx) begin
        if (in_acc) begin
            err_q <= in_pkt.err;
            if (!LATCH_META_ON_SOP || sop) begin
                meta_q <= in_pkt.meta;
            end
        end
    end

    assign out_pkt.err  = err_q;
    assign out_pkt.meta = meta_q;

endmodule : packet_width_converter

`default_nettype wire

// File: source/packet_fifo.sv
/*
 * Packet word FIFO with valid/ready on both sides. Entries sit in a
 * circular memory and the oldest one is shown from an output register.
 */

`default_nettype none

module packet_fifo
    import packet_pkg::*;
#(
    // Capacity in words, a power of two of at least 2
    parameter int DEPTH = 4
) (
    input  logic    from_tx,
    input  logic    srst,
    packet_intf.rx  in_pkt,
    packet_intf.tx  out_pkt
);

    localparam int WORD_BYTES = in_pkt.DATA_BYTES;
    localparam int MTY_W      = mty_width(WORD_BYTES);
    localparam int ENTRY_W    = WORD_BYTES * 8 + 1 + MTY_W + 1 + META_WID;
    localparam int PTR_W      = $clog2(DEPTH);
    localparam int CNT_W      = $clog2(DEPTH + 1);

    logic [ENTRY_W-1:0]  mem [DEPTH];
    logic [ENTRY_W-1:0]  in_word;
    logic [ENTRY_W-1:0]  head;
    logic                head_vld;
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;

    // Words held in total, the one in the head register included
    logic [CNT_W-1:0]    count;
    logic [CNT_W-1:0]    mem_cnt;

    logic                wr;
    logic                rd;
    logic                head_load;
    logic                bypass;

    assign in_word = {in_pkt.data, in_pkt.eop, in_pkt.mty, in_pkt.err, in_pkt.meta};

    assign wr = in_pkt.vld && in_pkt.rdy;
    assign rd = out_pkt.vld && out_pkt.rdy;

    assign mem_cnt   = count - CNT_W'(head_vld);
    assign head_load = !head_vld || rd;

    // With the memory empty, a new word goes straight into the head register
    assign bypass = head_load && (mem_cnt == '0);

    assign in_pkt.rdy = (count != CNT_W'(DEPTH));

    always_ff @(posedge from_tx) begin
        if (srst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            head_vld <= 1'b0;
        end else begin
            count <= count + CNT_W'(wr) - CNT_W'(rd);
            if (wr && !bypass) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head_load) begin
                if (mem_cnt != '0) begin
                    rd_ptr   <= rd_ptr + 1'b1;
                    head_vld <= 1'b1;
                end else begin
                    head_vld <= wr;
                end
            end
        end
    end

    always_ff @(posedge from_tx) begin
        if (wr && !bypass) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // Refill the head from the oldest stored word, or from the input
    always_ff @(posedge from_tx) begin
        if (head_load) begin
            if (mem_cnt != '0) begin
                head <= mem[rd_ptr];
            end else if (wr) begin
                head <= in_word;
            end
        end
    end

    assign out_pkt.vld = head_vld;
    assign {out_pkt.data, out_pkt.eop, out_pkt.mty, out_pkt.err, out_pkt.meta} = head;

endmodule : packet_fifo

`default_nettype wire

// File: source/packet_regauge.sv
/*
 * Packet regauging path top level: upsizer, packet FIFO and downsizer
 * joined by stream interfaces, with plain stream ports on both ends.
 */

`default_nettype none

module packet_regauge
    import packet_pkg::*;
#(
    parameter int IN_BYTES          = packet_pkg::IN_BYTES,
    parameter int MID_BYTES         = packet_pkg::MID_BYTES,
    parameter int OUT_BYTES         = packet_pkg::OUT_BYTES,
    parameter int FIFO_DEPTH        = 4,
    parameter bit LATCH_META_ON_SOP = 1'b1
) (
    input  logic                              from_tx,
    input  logic                              srst,

    input  logic                              in_vld,
    output logic                              in_rdy,
    input  logic [IN_BYTES*8-1:0]             in_data,
    input  logic                              in_eop,
    input  logic [mty_width(IN_BYTES)-1:0]    in_mty,
    input  logic                              in_err,
    input  logic [META_WID-1:0]               in_meta,

    output logic                              out_vld,
    input  logic                              out_rdy,
    output logic [OUT_BYTES*8-1:0]            out_data,
    output logic                              out_eop,
    output logic [mty_width(OUT_BYTES)-1:0]   out_mty,
    output logic                              out_err,
    output logic [META_WID-1:0]               out_meta
);

    packet_intf #(.DATA_BYTES(IN_BYTES))  in_if   ();
    packet_intf #(.DATA_BYTES(MID_BYTES)) wide_up ();
    packet_intf #(.DATA_BYTES(MID_BYTES)) wide_dn ();
    packet_intf #(.DATA_BYTES(OUT_BYTES)) out_if  ();

    // Input stream onto its interface
    assign in_if.vld  = in_vld;
    assign in_rdy     = in_if.rdy;
    assign in_if.data = in_data;
    assign in_if.eop  = in_eop;
    assign in_if.mty  = in_mty;
    assign in_if.err  = in_err;
    assign in_if.meta = in_meta;

    packet_width_converter #(
        .LATCH_META_ON_SOP (LATCH_META_ON_SOP)
    ) up0 (
        .from_tx (from_tx),
        .srst    (srst),
        .in_pkt  (in_if),
        .out_pkt (wide_up)
    );

    packet_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .from_tx (from_tx),
        .srst    (srst),
        .in_pkt  (wide_up),
        .out_pkt (wide_dn)
    );

    packet_width_converter #(
        .LATCH_META_ON_SOP (LATCH_META_ON_SOP)
    ) dn0 (
        .from_tx (from_tx),
        .srst    (srst),
        .in_pkt  (wide_dn),
        .out_pkt (out_if)
    );

    // Output stream off its interface
    assign out_vld    = out_if.vld;
    assign out_if.rdy = out_rdy;
    assign out_data   = out_if.data;
    assign out_eop    = out_if.eop;
    assign out_mty    = out_if.mty;
    assign out_err    = out_if.err;
    assign out_meta   = out_if.meta;

endmodule : packet_regauge

`default_nettype wire

// File: tests/packet_regauge_tb.sv
/*
 * Testbench for the packet regauging path: a table of packets driven on the
 * 2-byte input, an LCG-driven out_rdy, a reference byte queue and typed
 * compare tasks for bytes, metadata, flags and the output empty count.
 */

`default_nettype none

module packet_regauge_tb
    import packet_pkg::*;
();

    localparam int NUM_PKTS       = 12;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int IN_MTY_W       = mty_width(IN_BYTES);
    localparam int OUT_MTY_W      = mty_width(OUT_BYTES);

    logic                    from_tx;
    logic                    srst;
    logic                    in_vld;
    logic                    in_rdy;
    logic [IN_BYTES*8-1:0]   in_data;
    logic                    in_eop;
    logic [IN_MTY_W-1:0]     in_mty;
    logic                    in_err;
    meta_t                   in_meta;
    logic                    out_vld;
    logic                    out_rdy;
    logic [OUT_BYTES*8-1:0]  out_data;
    logic                    out_eop;
    logic [OUT_MTY_W-1:0]    out_mty;
    logic                    out_err;
    meta_t                   out_meta;

    // Packet table, one column per field: length, first byte, metadata,
    // error flag and whether idle cycles are put between input beats
    int    pkt_len      [NUM_PKTS] = '{1, 2, 3, 4, 5, 7, 8, 11, 13, 16, 19, 21};
    byte_t pkt_first    [NUM_PKTS] = '{8'h10, 8'h20, 8'h30, 8'h40, 8'h50, 8'h60,
                                       8'h70, 8'h80, 8'h90, 8'ha0, 8'hb0, 8'hf5};
    meta_t pkt_sop_meta [NUM_PKTS] = '{8'h01, 8'h12, 8'h23, 8'h34, 8'h45, 8'h56,
                                       8'h67, 8'h78, 8'h89, 8'h9a, 8'hab, 8'hbc};
    meta_t pkt_eop_meta [NUM_PKTS] = '{8'hc1, 8'hc2, 8'hc3, 8'hc4, 8'hc5, 8'hc6,
                                       8'hc7, 8'hc8, 8'hc9, 8'hca, 8'hcb, 8'hcc};
    logic  pkt_err      [NUM_PKTS] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0,
                                       1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    logic  pkt_gap      [NUM_PKTS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0,
                                       1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};

    byte_t        byte_q[$];
    int           value_errors = 0;
    int           other_errors = 0;
    logic [31:0]  lcg_state;

    packet_regauge dut0 (
        .from_tx  (from_tx),
        .srst     (srst),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .in_data  (in_data),
        .in_eop   (in_eop),
        .in_mty   (in_mty),
        .in_err   (in_err),
        .in_meta  (in_meta),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_data (out_data),
        .out_eop  (out_eop),
        .out_mty  (out_mty),
        .out_err  (out_err),
        .out_meta (out_meta)
    );

    initial begin
        from_tx = 1'b0;
        forever #10 from_tx = ~from_tx;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Output ready is high on about one cycle in four
    initial begin
        lcg_state = 32'd5613;
        out_rdy   = 1'b0;
        forever begin
            @(posedge from_tx);
            lcg_state = lcg_next(lcg_state);
            out_rdy <= (lcg_state[31:30] == 2'b00);
        end
    end

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_meta(input string name, input meta_t exp, input meta_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_mty(input string name, input logic [OUT_MTY_W-1:0] exp,
                             input logic [OUT_MTY_W-1:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    // Returns at the rising edge on which the current input beat transfers
    task automatic wait_in_ready(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b1;
        @(negedge from_tx);
        while (!in_rdy) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("ERROR: in_rdy stayed low for %0d cycles", TIMEOUT_CYCLES);
                other_errors++;
                ok = 1'b0;
                return;
            end
            @(negedge from_tx);
            cycles++;
        end
        @(posedge from_tx);
    endtask

    // Returns on the falling edge before an output word transfers
    task automatic wait_out_word(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b1;
        @(negedge from_tx);
        while (!(out_vld && out_rdy)) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("ERROR: no output word for %0d cycles", TIMEOUT_CYCLES);
                other_errors++;
                ok = 1'b0;
                return;
            end
            @(negedge from_tx);
            cycles++;
        end
    endtask

    task automatic drive_packets();
        int                     nbeats;
        int                     idx;
        bit                     ok;
        logic [IN_BYTES*8-1:0]  word;
        @(posedge from_tx);
        for (int p = 0; p < NUM_PKTS; p++) begin
            nbeats = (pkt_len[p] + IN_BYTES - 1) / IN_BYTES;
            for (int b = 0; b < nbeats; b++) begin
                word = '0;
                for (int k = 0; k < IN_BYTES; k++) begin
                    idx = b * IN_BYTES + k;
                    if (idx < pkt_len[p]) begin
                        word[IN_BYTES*8-1-8*k -: 8] = byte_t'(pkt_first[p] + idx);
                    end
                end
                in_vld  <= 1'b1;
                in_data <= word;
                in_eop  <= (b == nbeats - 1);
                in_mty  <= (b == nbeats - 1) ?
                    IN_MTY_W'((IN_BYTES - pkt_len[p] % IN_BYTES) % IN_BYTES) : '0;
                in_err  <= (b == nbeats - 1) ? pkt_err[p] : 1'b0;
                in_meta <= (b == 0) ? pkt_sop_meta[p] : pkt_eop_meta[p];
                wait_in_ready(ok);
                if (!ok) begin
                    in_vld <= 1'b0;
                    return;
                end
                if (pkt_gap[p]) begin
                    in_vld <= 1'b0;
                    @(posedge from_tx);
                end
            end
        end
        in_vld <= 1'b0;
    endtask

    task automatic collect_packets();
        int     nwords;
        int     nvalid;
        int     exp_mty;
        bit     last;
        bit     ok;
        byte_t  exp_byte;
        string  tag;
        for (int p = 0; p < NUM_PKTS; p++) begin
            nwords  = (pkt_len[p] + OUT_BYTES - 1) / OUT_BYTES;
            exp_mty = (OUT_BYTES - pkt_len[p] % OUT_BYTES) % OUT_BYTES;
            for (int w = 0; w < nwords; w++) begin
                wait_out_word(ok);
                if (!ok) begin
                    $display("ERROR: packet %0d stopped after %0d of %0d words", p, w, nwords);
                    return;
                end
                last   = (w == nwords - 1);
                nvalid = last ? OUT_BYTES - exp_mty : OUT_BYTES;
                tag    = $sformatf("pkt%0d word%0d", p, w);
                for (int k = 0; k < nvalid; k++) begin
                    exp_byte = byte_q.pop_front();
                    check_byte($sformatf("%s byte%0d", tag, k), exp_byte,
                               out_data[OUT_BYTES*8-1-8*k -: 8]);
                end
                check_flag({tag, " eop"}, last, out_eop);
                if (last) begin
                    check_mty({tag, " mty"}, OUT_MTY_W'(exp_mty), out_mty);
                    check_meta({tag, " meta"}, pkt_sop_meta[p], out_meta);
                    check_flag({tag, " err"}, pkt_err[p], out_err);
                end
            end
        end
    endtask

    initial begin
        srst    = 1'b1;
        in_vld  = 1'b0;
        in_data = '0;
        in_eop  = 1'b0;
        in_mty  = '0;
        in_err  = 1'b0;
        in_meta = '0;

        for (int p = 0; p < NUM_PKTS; p++) begin
            for (int i = 0; i < pkt_len[p]; i++) begin
                byte_q.push_back(byte_t'(pkt_first[p] + i));
            end
        end

        repeat (4) @(posedge from_tx);
        srst <= 1'b0;

        @(negedge from_tx);
        check_flag("reset out_vld", 1'b0, out_vld);
        check_flag("reset in_rdy", 1'b1, in_rdy);

        fork
            drive_packets();
            collect_packets();
        join

        // Nothing more may come out once every packet has been seen
        repeat (20) begin
            @(negedge from_tx);
            if (out_vld) begin
                $display("ERROR: output word present after the last packet");
                other_errors++;
            end
        end
        if (byte_q.size() != 0) begin
            $display("ERROR: %0d reference bytes never reached the output", byte_q.size());
            other_errors++;
        end

        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : packet_regauge_tb

`default_nettype wire

// File: sim.f
source/packet_pkg.sv
source/packet_intf.sv
source/packet_width_converter.sv
source/packet_fifo.sv
source/packet_regauge.sv
tests/packet_regauge_tb.sv

// File: Bender.yml
package:
  name: packet_regauge

dependencies: {}

sources:
  # RTL in compile order
  - source/packet_pkg.sv
  - source/packet_intf.sv
  - source/packet_width_converter.sv
  - source/packet_fifo.sv
  - source/packet_regauge.sv

  # Testbench, top module packet_regauge_tb
  - target: test
    files:
      - tests/packet_regauge_tb.sv
